// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 \
		--top-module tb_zxuno_regs -f filelist.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: design/config_regs.sv
`timescale 1ns/1ps

module config_regs (
   input  logic                        sysclk,
   input  logic                        rst,
   input  logic [7:0]                  reg_addr,
   input  logic                        reg_rd,
   input  logic                        reg_wr,
   input  logic [7:0]                  wdata,
   output zxuno_cfg_pkg::dev_options_t dev_options,
   output zxuno_cfg_pkg::scandbl_cfg_t scandbl,
   output zxuno_bus_pkg::rd_src_t      rd_src
);

   import zxuno_bus_pkg::*;
   import zxuno_cfg_pkg::*;

   // ------------------------------------------------------------------
   // write side
   // ------------------------------------------------------------------

   // both registers are loaded whole
   always_ff @(posedge sysclk) begin
      if (rst) begin
         dev_options <= DEV_OPTIONS_RST;
         scandbl     <= SCANDBL_RST;
      end else if (reg_wr) begin
         case (reg_addr)
            REG_DEVOPTIONS: dev_options <= dev_options_t'(wdata);
            REG_SCANDBL:    scandbl     <= scandbl_cfg_t'(wdata);
            default:        ;
         endcase
      end
   end

   // ------------------------------------------------------------------
   // readback
   // ------------------------------------------------------------------

   always_comb begin
      rd_src.oe   = 1'b0;
      rd_src.data = 8'h00;
      if (reg_rd) begin
         case (reg_addr)
            REG_DEVOPTIONS: begin
               rd_src.oe   = 1'b1;
               rd_src.data = dev_options;
            end
            REG_SCANDBL: begin
               rd_src.oe   = 1'b1;
               rd_src.data = scandbl;
            end
            default: ;
         endcase
      end
   end

endmodule

// File: design/coreid_rom.sv
`timescale 1ns/1ps

module coreid_rom #(
   parameter int                     CORE_ID_LEN = 8,
   parameter logic [8*CORE_ID_LEN-1:0] CORE_ID   = "CFGREGS1"
) (
   input  logic                    sysclk,
   input  logic                    rst,
   input  logic [7:0]              reg_addr,
   input  logic                    reg_rd,
   input  logic                    regaddr_changed,
   output zxuno_bus_pkg::rd_src_t  rd_src
);

   import zxuno_bus_pkg::*;

   localparam int PTR_W = $clog2(CORE_ID_LEN + 1);
   localparam logic [PTR_W-1:0] PTR_END = PTR_W'(CORE_ID_LEN);

   logic [PTR_W-1:0]         ptr;
   logic [8*CORE_ID_LEN-1:0] id_shifted;
   logic                     id_read;

   assign id_read = reg_rd && (reg_addr == REG_COREID);

   // current char ends up in the top byte
   // past the end everything has shifted out and the byte reads 0x00
   assign id_shifted = CORE_ID << (8 * ptr);

   // ------------------------------------------------------------------
   // string pointer
   // ------------------------------------------------------------------

   always_ff @(posedge sysclk) begin
      if (rst) begin
         ptr <= '0;
      end else if (regaddr_changed) begin
         // any address port write rewinds
         ptr <= '0;
      end else if (id_read && ptr != PTR_END) begin
         ptr <= ptr + 1'b1;
      end
   end

   assign rd_src.oe   = id_read;
   assign rd_src.data = id_shifted[8*CORE_ID_LEN-1 -: 8];

   // pointer parks at the terminator
   a_ptr_in_range: assert property (@(posedge sysclk) disable iff (rst) ptr <= PTR_END)
      else $error("coreid pointer past end of string");

endmodule

// File: design/cpu_read_mux.sv
`timescale 1ns/1ps

module cpu_read_mux (
   input  zxuno_bus_pkg::rd_src_t src_addr,
   input  zxuno_bus_pkg::rd_src_t src_coreid,
   input  zxuno_bus_pkg::rd_src_t src_cfg,
   input  zxuno_bus_pkg::rd_src_t src_raster,
   output logic [7:0]             rdata
);

   import zxuno_bus_pkg::*;

   // ------------------------------------------------------------------
   // fixed priority, first enabled source wins
   // ------------------------------------------------------------------

   always_comb begin
      if (src_addr.oe) begin
         rdata = src_addr.data;
      end else if (src_coreid.oe) begin
         rdata = src_coreid.data;
      end else if (src_cfg.oe) begin
         rdata = src_cfg.data;
      end else if (src_raster.oe) begin
         rdata = src_raster.data;
      end else begin
         // nobody claimed the cycle
         rdata = FLOATING_BUS;
      end
   end

   // decode in the register blocks never overlaps
   always_comb begin
      a_single_driver: assert final ($onehot0({src_addr.oe, src_coreid.oe,
                                               src_cfg.oe, src_raster.oe}))
         else $error("more than one read source enabled");
   end

endmodule

// File: design/rasterint_ctrl.sv
`timescale 1ns/1ps

module rasterint_ctrl (
   input  logic                          sysclk,
   input  logic                          rst,
   input  logic [7:0]                    reg_addr,
   input  logic                          reg_rd,
   input  logic                          reg_wr,
   input  logic [7:0]                    wdata,
   input  logic                          raster_int_in_progress,
   output zxuno_cfg_pkg::rasterint_cfg_t rasterint,
   output zxuno_bus_pkg::rd_src_t        rd_src
);

   import zxuno_bus_pkg::*;
   import zxuno_cfg_pkg::*;

   // ------------------------------------------------------------------
   // line low byte in 0x0C, line msb and flags in 0x0D
   // ------------------------------------------------------------------

   always_ff @(posedge sysclk) begin
      if (rst) begin
         rasterint <= RASTERINT_RST;
      end else if (reg_wr && reg_addr == REG_RASTER_LINE) begin
         rasterint.raster_line[7:0] <= wdata;
      end else if (reg_wr && reg_addr == REG_RASTER_CTRL) begin
         rasterint.raster_line[8]       <= wdata[0];
         rasterint.rasterint_enable     <= wdata[1];
         rasterint.vretraceint_disable  <= wdata[2];
      end
   end

   // status bit 7 comes live from the video side
   always_comb begin
      rd_src.oe   = 1'b0;
      rd_src.data = 8'h00;
      if (reg_rd && reg_addr == REG_RASTER_LINE) begin
         rd_src.oe   = 1'b1;
         rd_src.data = rasterint.raster_line[7:0];
      end else if (reg_rd && reg_addr == REG_RASTER_CTRL) begin
         rd_src.oe   = 1'b1;
         rd_src.data = {raster_int_in_progress, 4'b0000,
                        rasterint.vretraceint_disable,
                        rasterint.rasterint_enable,
                        rasterint.raster_line[8]};
      end
   end

endmodule

// File: design/zxuno_addr_reg.sv
`timescale 1ns/1ps

module zxuno_addr_reg (
   input  logic                    sysclk,
   input  logic                    rst,
   input  zxuno_bus_pkg::io_req_t  io,
   output logic [7:0]              reg_addr,
   output logic                    reg_rd,
   output logic                    reg_wr,
   output logic                    regaddr_changed,
   output zxuno_bus_pkg::rd_src_t  rd_src
);

   import zxuno_bus_pkg::*;

   logic hit_addr_port;
   logic hit_data_port;

   // ------------------------------------------------------------------
   // port decode, full 16 bit compare
   // ------------------------------------------------------------------

   assign hit_addr_port = (io.addr == PORT_REGADDR);
   assign hit_data_port = (io.addr == PORT_REGDATA);

   // strobes for the register blocks
   assign reg_rd          = io.rd && hit_data_port;
   assign reg_wr          = io.wr && hit_data_port;
   assign regaddr_changed = io.wr && hit_addr_port;

   // selected register number
   always_ff @(posedge sysclk) begin
      if (rst) begin
         reg_addr <= 8'h00;
      end else if (regaddr_changed) begin
         reg_addr <= io.wdata;
      end
   end

   // address port is readable too
   assign rd_src.oe   = io.rd && hit_addr_port;
   assign rd_src.data = reg_addr;

   // cpu never reads and writes in the same cycle
   property p_no_rd_wr_overlap;
      @(posedge sysclk) disable iff (rst)
         !(io.rd && io.wr);
   endproperty

   a_no_rd_wr_overlap: assert property (p_no_rd_wr_overlap)
      else $error("io.rd and io.wr high together");

endmodule

// File: design/zxuno_bus_pkg.sv
package zxuno_bus_pkg;

   // ------------------------------------------------------------------
   // cpu side i/o bus
   // ------------------------------------------------------------------

   // one cpu i/o cycle, rd and wr never together
   typedef struct packed {
      logic [15:0] addr;
      logic        rd;
      logic        wr;
      logic [7:0]  wdata;
   } io_req_t;

   // what one register block offers to the read path
   typedef struct packed {
      logic [7:0] data;
      logic       oe;
   } rd_src_t;

   // ------------------------------------------------------------------
   // register bank addressing
   // ------------------------------------------------------------------

   // indexed register numbers behind the data port
   typedef enum logic [7:0] {
      REG_SCANDBL     = 8'h0B,
      REG_RASTER_LINE = 8'h0C,
      REG_RASTER_CTRL = 8'h0D,
      REG_DEVOPTIONS  = 8'h0E,
      REG_COREID      = 8'hFF
   } reg_addr_e;

   // full 16 bit decode for both ports
   localparam logic [15:0] PORT_REGADDR = 16'hFC3B;
   localparam logic [15:0] PORT_REGDATA = 16'hFD3B;

   // value seen by the cpu when nobody drives the bus
   localparam logic [7:0] FLOATING_BUS = 8'hFF;

endpackage

// File: design/zxuno_cfg_pkg.sv
package zxuno_cfg_pkg;

   // ------------------------------------------------------------------
   // configuration outputs of the register bank
   // ------------------------------------------------------------------

   // device enable options, bit 7 down to bit 0
   typedef struct packed {
      logic disable_mixer;
      logic disable_specdrum;
      logic disable_radas;
      logic disable_ulaplus;
      logic disable_timexscr;
      logic disable_spisd;
      logic disable_turboay;
      logic disable_ay;
   } dev_options_t;

   // scandoubler and cpu speed control
   typedef struct packed {
      // cpu clock multiplier select
      logic [1:0] turbo;
      // vertical refresh option
      logic [2:0] freq_option;
      logic       csync_option;
      logic       scanlines_enable;
      logic       vga_enable;
   } scandbl_cfg_t;

   // raster interrupt setup
   typedef struct packed {
      logic [8:0] raster_line;
      logic       rasterint_enable;
      logic       vretraceint_disable;
   } rasterint_cfg_t;

   // power up values
   localparam dev_options_t   DEV_OPTIONS_RST = '0;
   localparam scandbl_cfg_t   SCANDBL_RST     = '0;
   localparam rasterint_cfg_t RASTERINT_RST   = '0;

endpackage

// File: design/zxuno_regs_top.sv
`timescale 1ns/1ps

module zxuno_regs_top #(
   parameter int                       CORE_ID_LEN = 8,
   parameter logic [8*CORE_ID_LEN-1:0] CORE_ID     = "CFGREGS1"
) (
   input  logic                          sysclk,
   input  logic                          rst,
   input  zxuno_bus_pkg::io_req_t        io,
   input  logic                          raster_int_in_progress,
   output logic [7:0]                    rdata,
   output zxuno_cfg_pkg::dev_options_t   dev_options,
   output zxuno_cfg_pkg::scandbl_cfg_t   scandbl,
   output zxuno_cfg_pkg::rasterint_cfg_t rasterint
);

   import zxuno_bus_pkg::*;

   // shared register strobes
   logic [7:0] reg_addr;
   logic       reg_rd;
   logic       reg_wr;
   logic       regaddr_changed;

   // read path sources
   rd_src_t src_addr;
   rd_src_t src_coreid;
   rd_src_t src_cfg;
   rd_src_t src_raster;

   // ------------------------------------------------------------------
   // register bank
   // ------------------------------------------------------------------

   zxuno_addr_reg i_zxuno_addr_reg (
      .sysclk          (sysclk),
      .rst             (rst),
      .io              (io),
      .reg_addr        (reg_addr),
      .reg_rd          (reg_rd),
      .reg_wr          (reg_wr),
      .regaddr_changed (regaddr_changed),
      .rd_src          (src_addr)
   );

   coreid_rom #(
      .CORE_ID_LEN (CORE_ID_LEN),
      .CORE_ID     (CORE_ID)
   ) i_coreid_rom (
      .sysclk          (sysclk),
      .rst             (rst),
      .reg_addr        (reg_addr),
      .reg_rd          (reg_rd),
      .regaddr_changed (regaddr_changed),
      .rd_src          (src_coreid)
   );

   config_regs i_config_regs (
      .sysclk      (sysclk),
      .rst         (rst),
      .reg_addr    (reg_addr),
      .reg_rd      (reg_rd),
      .reg_wr      (reg_wr),
      .wdata       (io.wdata),
      .dev_options (dev_options),
      .scandbl     (scandbl),
      .rd_src      (src_cfg)
   );

   rasterint_ctrl i_rasterint_ctrl (
      .sysclk                 (sysclk),
      .rst                    (rst),
      .reg_addr               (reg_addr),
      .reg_rd                 (reg_rd),
      .reg_wr                 (reg_wr),
      .wdata                  (io.wdata),
      .raster_int_in_progress (raster_int_in_progress),
      .rasterint              (rasterint),
      .rd_src                 (src_raster)
   );

   // byte back to the cpu
   cpu_read_mux i_cpu_read_mux (
      .src_addr   (src_addr),
      .src_coreid (src_coreid),
      .src_cfg    (src_cfg),
      .src_raster (src_raster),
      .rdata      (rdata)
   );

endmodule

// File: dv/tb_reg_model.sv
`timescale 1ns/1ps

module tb_reg_model #(
   parameter int                  ID_LEN = 8,
   parameter logic [8*ID_LEN-1:0] ID_STR = "CFGREGS1"
);

   // port numbers kept local to the model
   localparam logic [15:0] ADDR_PORT = 16'hFC3B;
   localparam logic [15:0] DATA_PORT = 16'hFD3B;

   // ------------------------------------------------------------------
   // expected register bank state
   // ------------------------------------------------------------------

   logic [7:0] sel;
   logic [7:0] devopt;
   logic [7:0] scan;
   logic [8:0] line;
   logic       ri_en;
   logic       vr_dis;
   int         ptr;

   function automatic void model_reset();
      sel    = 8'h00;
      devopt = 8'h00;
      scan   = 8'h00;
      line   = 9'h000;
      ri_en  = 1'b0;
      vr_dis = 1'b0;
      ptr    = 0;
   endfunction

   // address port write also rewinds the id string
   function automatic void model_write(input logic [15:0] port, input logic [7:0] data);
      if (port == ADDR_PORT) begin
         sel = data;
         ptr = 0;
      end else if (port == DATA_PORT) begin
         case (sel)
            8'h0B: scan = data;
            8'h0C: line[7:0] = data;
            8'h0D: begin
               line[8] = data[0];
               ri_en   = data[1];
               vr_dis  = data[2];
            end
            8'h0E: devopt = data;
            default: ;
         endcase
      end
   endfunction

   // expected byte for a read, steps the id pointer
   function automatic logic [7:0] model_read(input logic [15:0] port, input logic irq);
      logic [7:0] v;
      v = 8'hFF;
      if (port == ADDR_PORT) begin
         v = sel;
      end else if (port == DATA_PORT) begin
         case (sel)
            8'h0B: v = scan;
            8'h0C: v = line[7:0];
            8'h0D: v = {irq, 4'b0000, vr_dis, ri_en, line[8]};
            8'h0E: v = devopt;
            8'hFF: begin
               if (ptr < ID_LEN) begin
                  // first char sits in the top byte
                  v   = ID_STR[8*(ID_LEN-1-ptr) +: 8];
                  ptr = ptr + 1;
               end else begin
                  v = 8'h00;
               end
            end
            default: v = 8'hFF;
         endcase
      end
      return v;
   endfunction

   function automatic logic [7:0] exp_dev_options();
      return devopt;
   endfunction

   function automatic logic [7:0] exp_scandbl();
      return scan;
   endfunction

   // line, enable, vretrace disable
   function automatic logic [10:0] exp_rasterint();
      return {line, ri_en, vr_dis};
   endfunction

endmodule

// File: dv/tb_zxuno_regs.sv
`timescale 1ns/1ps

module tb_zxuno_regs;

   import zxuno_bus_pkg::*;
   import zxuno_cfg_pkg::*;

   // different from the rtl default string
   localparam int                  ID_LEN = 8;
   localparam logic [8*ID_LEN-1:0] ID_STR = "ZXCFG-01";

   // rough access count over all phases, 2 cycles each, 4x margin
   localparam int N_ACCESS    = 400;
   localparam int WATCHDOG_NS = N_ACCESS * 2 * 8 * 4 + 8 * 8;

   localparam io_req_t IO_IDLE = '0;

   logic           sysclk;
   logic           rst;
   io_req_t        io;
   logic           raster_int_in_progress;
   logic [7:0]     rdata;
   dev_options_t   dev_options;
   scandbl_cfg_t   scandbl;
   rasterint_cfg_t rasterint;

   int errors;
   int checks;

   zxuno_regs_top #(
      .CORE_ID_LEN (ID_LEN),
      .CORE_ID     (ID_STR)
   ) i_zxuno_regs_top (
      .sysclk                 (sysclk),
      .rst                    (rst),
      .io                     (io),
      .raster_int_in_progress (raster_int_in_progress),
      .rdata                  (rdata),
      .dev_options            (dev_options),
      .scandbl                (scandbl),
      .rasterint              (rasterint)
   );

   tb_reg_model #(
      .ID_LEN (ID_LEN),
      .ID_STR (ID_STR)
   ) i_reg_model ();

   // 8 ns clock
   initial begin
      sysclk = 1'b0;
      forever #4 sysclk = ~sysclk;
   end

   // ------------------------------------------------------------------
   // checks and bus access tasks
   // ------------------------------------------------------------------

   task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] got);
      checks++;
      a_value: assert (got === exp) else begin
         errors++;
         $display("Fail %s expected %h got %h", name, exp, got);
      end
   endtask

   // config outputs against the model
   task automatic check_outputs();
      check_val("dev_options", 16'(i_reg_model.exp_dev_options()), 16'(dev_options));
      check_val("scandbl", 16'(i_reg_model.exp_scandbl()), 16'(scandbl));
      check_val("rasterint", 16'(i_reg_model.exp_rasterint()), 16'(rasterint));
   endtask

   // access cycle, then idle cycle; outputs checked mid idle
   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge sysclk);
      io <= {addr, 1'b0, 1'b1, data};
      @(posedge sysclk);
      io <= IO_IDLE;
      i_reg_model.model_write(addr, data);
      @(negedge sysclk);
      check_outputs();
   endtask

   // rdata sampled mid cycle of the read itself
   task automatic bus_read(input logic [15:0] addr);
      logic [7:0] exp;
      @(posedge sysclk);
      io <= {addr, 1'b1, 1'b0, 8'h00};
      @(negedge sysclk);
      exp = i_reg_model.model_read(addr, raster_int_in_progress);
      check_val("rdata", 16'(exp), 16'(rdata));
      @(posedge sysclk);
      io <= IO_IDLE;
   endtask

   task automatic set_irq(input logic v);
      @(posedge sysclk);
      raster_int_in_progress <= v;
   endtask

   function automatic logic is_mapped(input logic [7:0] r);
      return (r == 8'h0B) || (r == 8'h0C) || (r == 8'h0D) || (r == 8'h0E) || (r == 8'hFF);
   endfunction

   // mostly mapped register numbers, some random
   function automatic logic [7:0] pick_reg();
      int unsigned r;
      r = $urandom_range(0, 11);
      case (r)
         0, 1:    return 8'h0B;
         2, 3:    return 8'h0C;
         4, 5:    return 8'h0D;
         6, 7:    return 8'h0E;
         8, 9:    return 8'hFF;
         default: return 8'($urandom);
      endcase
   endfunction

   task automatic random_access();
      int unsigned r;
      r = $urandom_range(0, 99);
      if (r < 20) begin
         bus_write(PORT_REGADDR, pick_reg());
      end else if (r < 45) begin
         bus_write(PORT_REGDATA, 8'($urandom));
      end else if (r < 55) begin
         bus_read(PORT_REGADDR);
      end else if (r < 85) begin
         bus_read(PORT_REGDATA);
      end else if (r < 90) begin
         set_irq(1'($urandom_range(0, 1)));
      end else if (r < 95) begin
         bus_write(16'($urandom), 8'($urandom));
      end else begin
         bus_read(16'($urandom));
      end
   endtask

   // ------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------

   initial begin
      logic [7:0] v;
      int         i;
      void'($urandom(31278));
      errors                 = 0;
      checks                 = 0;
      rst                    = 1'b1;
      io                     = IO_IDLE;
      raster_int_in_progress = 1'b0;
      i_reg_model.model_reset();
      repeat (8) @(posedge sysclk);
      rst <= 1'b0;

      // state right after reset
      @(negedge sysclk);
      check_outputs();
      bus_read(PORT_REGADDR);
      bus_read(16'h00FE);

      // address port readback, unclaimed register number
      bus_write(PORT_REGADDR, 8'($urandom));
      bus_read(PORT_REGADDR);
      v = 8'($urandom);
      while (is_mapped(v)) begin
         v = 8'($urandom);
      end
      bus_write(PORT_REGADDR, v);
      bus_read(PORT_REGDATA);
      bus_write(PORT_REGDATA, 8'($urandom));
      bus_read(PORT_REGDATA);

      // each config register, written and read back
      for (i = 0; i < 12; i++) begin
         bus_write(PORT_REGADDR, 8'h0B + 8'(i % 4));
         bus_write(PORT_REGDATA, 8'($urandom));
         bus_read(PORT_REGDATA);
      end

      // id string runs past its end, then restarts
      bus_write(PORT_REGADDR, 8'hFF);
      repeat (ID_LEN + 3) bus_read(PORT_REGDATA);
      bus_write(PORT_REGADDR, 8'hFF);
      repeat (3) bus_read(PORT_REGDATA);

      // live status bit in the raster control read
      bus_write(PORT_REGADDR, 8'h0D);
      repeat (10) begin
         set_irq(1'($urandom_range(0, 1)));
         bus_read(PORT_REGDATA);
      end

      repeat (300) random_access();

      @(posedge sysclk);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // stops a stuck run
   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the test sequence finished");
      $display("checks %0d errors %0d", checks, errors);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: filelist.f
design/zxuno_bus_pkg.sv
design/zxuno_cfg_pkg.sv
design/zxuno_addr_reg.sv
design/coreid_rom.sv
design/config_regs.sv
design/rasterint_ctrl.sv
design/cpu_read_mux.sv
design/zxuno_regs_top.sv
dv/tb_reg_model.sv
dv/tb_zxuno_regs.sv
